// File: acquisitionBuffer.sv
`timescale 1ns/1ps

module acquisitionBuffer import hsdPkg::*; #(
    parameter int captureDepth = defaultCaptureDepth
) (
    input  logic                            sysClk,
    input  logic                            rst,
    input  logic                            arm,
    input  triggerBus                       triggerEnable,
    input  sampleBeat                       beatIn,
    output logic                            armed,
    output logic                            captureDone,
    input  logic                            rdReq,
    input  logic [$clog2(captureDepth)-1:0] rdAddr,
    output logic                            rdAck,
    output sampleVector                     rdData
);

    localparam int addrWidth = $clog2(captureDepth);

    typedef enum logic [1:0] {
        capIdle,
        capArmed,
        capCapturing,
        capDone
    } captureState;

    typedef enum logic [1:0] {
        rdIdle,
        rdFetch,
        rdHold
    } readState;

    captureState          capState;
    readState             rdState;
    logic [addrWidth-1:0] wrAddr;
    logic                 triggerHit;
    logic                 wrEnable;
    logic                 lastWrite;
    logic                 rdReqSeen;
    sampleVector          bufferMem [captureDepth];

    ////////////////////////////////////////
    // Capture control

    // Any enabled strobe on a valid beat starts the record
    assign triggerHit = beatIn.valid && (|(beatIn.triggerStrobes & triggerEnable));

    assign wrEnable = !arm &&
                      ((capState == capArmed && triggerHit) ||
                       (capState == capCapturing && beatIn.valid));

    assign lastWrite = wrEnable && (wrAddr == addrWidth'(captureDepth - 1));

    always_ff @(posedge sysClk) begin
        if (rst) begin
            capState <= capIdle;
            wrAddr   <= '0;
        end else if (arm) begin
            // Re-arm from any state, drops a finished record
            capState <= capArmed;
            wrAddr   <= '0;
        end else if (wrEnable) begin
            wrAddr <= wrAddr + 1'b1;
            if (lastWrite) begin
                capState <= capDone;
            end else begin
                capState <= capCapturing;
            end
        end
    end

    assign armed       = (capState == capArmed) || (capState == capCapturing);
    assign captureDone = (capState == capDone);

    always_ff @(posedge sysClk) begin
        if (wrEnable) begin
            bufferMem[wrAddr] <= beatIn.samples;
        end
    end

    ////////////////////////////////////////
    // Readout handshake

    // Request registered first, then fetch, then acknowledge
    always_ff @(posedge sysClk) begin
        if (rst) begin
            rdReqSeen <= 1'b0;
            rdState   <= rdIdle;
        end else begin
            rdReqSeen <= rdReq;
            case (rdState)
                rdIdle: begin
                    if (rdReqSeen) begin
                        rdState <= rdFetch;
                    end
                end
                rdFetch: rdState <= rdHold;
                rdHold: begin
                    if (!rdReqSeen) begin
                        rdState <= rdIdle;
                    end
                end
                default: rdState <= rdIdle;
            endcase
        end
    end

    always_ff @(posedge sysClk) begin
        if (rdState == rdIdle && rdReqSeen) begin
            rdData <= bufferMem[rdAddr];
        end
    end

    assign rdAck = (rdState == rdHold);

    // Acknowledge only answers a request
    ackFollowsReq: assert property (
        @(posedge sysClk) disable iff (rst)
        $rose(rdAck) |-> $past(rdReq)
    ) else $error("rdAck rose without rdReq");

    // Writes only while armed, and the record ends armed or done
    writeWhileArmed: assert property (
        @(posedge sysClk) disable iff (rst)
        wrEnable |-> armed ##1 (armed || captureDone)
    ) else $error("Buffer write outside capture window");

endmodule

// File: adcRangeMonitor.sv
`timescale 1ns/1ps

module adcRangeMonitor import hsdPkg::*; (
    input  logic       sysClk,
    input  logic       rst,
    input  logic       rangeClear,
    input  sampleBeat  beatIn,
    output sampleBeat  beatOut,
    output rangeStatus range
);

    adcValue beatMin;
    adcValue beatMax;

    ////////////////////////////////////////
    // Beat pass-through

    always_ff @(posedge sysClk) begin
        if (rst) begin
            beatOut.valid          <= 1'b0;
            beatOut.triggerStrobes <= '0;
        end else begin
            beatOut.valid          <= beatIn.valid;
            beatOut.triggerStrobes <= beatIn.triggerStrobes;
        end
        beatOut.samples <= beatIn.samples;
    end

    ////////////////////////////////////////
    // Extremes tracking

    // Fold every lane into the running extremes
    always_comb begin
        adcValue laneTop;
        beatMin = range.minSample;
        beatMax = range.maxSample;
        for (int k = 0; k < samplesPerClock; k++) begin
            laneTop = laneValue(beatIn.samples[k]);
            if (laneTop < beatMin) begin
                beatMin = laneTop;
            end
            if (laneTop > beatMax) begin
                beatMax = laneTop;
            end
        end
    end

    // Clear wins over a beat in the same cycle
    always_ff @(posedge sysClk) begin
        if (rst || rangeClear) begin
            range.minSample <= adcMaxValue;
            range.maxSample <= adcMinValue;
        end else if (beatIn.valid) begin
            range.minSample <= beatMin;
            range.maxSample <= beatMax;
        end
    end

endmodule

// File: hsdDigitizer.sv
`timescale 1ns/1ps

module hsdDigitizer import hsdPkg::*; #(
    parameter int captureDepth = defaultCaptureDepth
) (
    input  logic                            sysClk,
    input  logic                            rst,
    input  sampleVector                     samples,
    input  logic                            sampleValid,
    input  logic [eventTriggerCount-1:0]    eventTriggers,
    input  logic                            softTrigger,
    input  logic                            rangeClear,
    input  triggerBus                       triggerEnable,
    input  logic                            arm,
    input  logic                            rdReq,
    input  logic [$clog2(captureDepth)-1:0] rdAddr,
    output rangeStatus                      range,
    output logic                            armed,
    output logic                            captureDone,
    output logic                            rdAck,
    output sampleVector                     rdData
);

    sampleBeat stageOneBeat;
    sampleBeat stageTwoBeat;

    ////////////////////////////////////////
    // Acquisition pipeline

    // Tags beats with trigger strobes
    triggerConditioner triggerConditioner_inst (
        .sysClk        (sysClk),
        .rst           (rst),
        .samples       (samples),
        .sampleValid   (sampleValid),
        .softTrigger   (softTrigger),
        .eventTriggers (eventTriggers),
        .stageOneBeat  (stageOneBeat)
    );

    adcRangeMonitor adcRangeMonitor_inst (
        .sysClk     (sysClk),
        .rst        (rst),
        .rangeClear (rangeClear),
        .beatIn     (stageOneBeat),
        .beatOut    (stageTwoBeat),
        .range      (range)
    );

    // Triggered record and host readout
    acquisitionBuffer #(
        .captureDepth (captureDepth)
    ) acquisitionBuffer_inst (
        .sysClk        (sysClk),
        .rst           (rst),
        .arm           (arm),
        .triggerEnable (triggerEnable),
        .beatIn        (stageTwoBeat),
        .armed         (armed),
        .captureDone   (captureDone),
        .rdReq         (rdReq),
        .rdAddr        (rdAddr),
        .rdAck         (rdAck),
        .rdData        (rdData)
    );

endmodule

// File: hsdPkg.sv
package hsdPkg;

    ////////////////////////////////////////
    // Converter geometry

    // Valid ADC bits per sample
    localparam int adcWidth = 12;
    localparam int samplesPerClock = 2;

    // Lane rounded up to whole bytes
    localparam int laneWidth = ((adcWidth + 7) / 8) * 8;

    ////////////////////////////////////////
    // Trigger sources

    // Bit 0 is software, the rest come from the event system
    localparam int triggerBusWidth = 7;
    localparam int eventTriggerCount = triggerBusWidth - 1;

    // Capture length in beats
    localparam int defaultCaptureDepth = 16;

    ////////////////////////////////////////
    // Data types

    // Left-justified, low bits zero
    typedef logic signed [laneWidth-1:0] sampleLane;
    typedef sampleLane [samplesPerClock-1:0] sampleVector;
    typedef logic [triggerBusWidth-1:0] triggerBus;
    typedef logic signed [adcWidth-1:0] adcValue;

    typedef struct packed {
        logic        valid;
        sampleVector samples;
        triggerBus   triggerStrobes;
    } sampleBeat;

    typedef struct packed {
        adcValue minSample;
        adcValue maxSample;
    } rangeStatus;

    // Extremes of the signed ADC code
    localparam adcValue adcMaxValue = adcValue'((1 << (adcWidth - 1)) - 1);
    localparam adcValue adcMinValue = adcValue'(1 << (adcWidth - 1));

    // Valid converter bits of one lane
    function automatic adcValue laneValue(sampleLane lane);
        return adcValue'(lane[laneWidth-1 -: adcWidth]);
    endfunction

endpackage

// File: project.f
+incdir+.
hsdPkg.sv
triggerConditioner.sv
adcRangeMonitor.sv
acquisitionBuffer.sv
hsdDigitizer.sv
tbHsdDigitizer.sv

// File: tbHsdTasks.svh
`ifndef TB_HSD_TASKS_SVH
`define TB_HSD_TASKS_SVH

////////////////////////////////////////
// Compare tasks

task automatic compareBeat(input string name, input sampleVector actual,
                           input sampleVector expected);
    checkCount++;
    if (actual !== expected) begin
        errorCount++;
        $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
endtask

task automatic compareRange(input string name, input rangeStatus actual,
                            input rangeStatus expected);
    checkCount++;
    if (actual !== expected) begin
        errorCount++;
        $display("Mismatch at %0t: %s is min %0d max %0d, expected min %0d max %0d",
                 $time, name, actual.minSample, actual.maxSample,
                 expected.minSample, expected.maxSample);
    end
endtask

task automatic compareBit(input string name, input logic actual, input logic expected);
    checkCount++;
    if (actual !== expected) begin
        errorCount++;
        $display("Mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
    end
endtask

task automatic reportFailure(input string what);
    errorCount++;
    $display("Error at %0t: %s", $time, what);
endtask

////////////////////////////////////////
// Stimulus

// Lane k of beat n carries code 2n+k
function automatic sampleVector countedSamples(input int beatNum);
    sampleVector         vec;
    logic [adcWidth-1:0] code;
    for (int k = 0; k < samplesPerClock; k++) begin
        code = adcWidth'(beatNum * samplesPerClock + k);
        vec[k] = {code, {(laneWidth - adcWidth){1'b0}}};
    end
    return vec;
endfunction

task automatic driveBeat(input logic valid, input bit useRandom);
    sampleVector vec;
    drivenBeat   entry;
    int          rawValue;
    @(negedge sysClk);
    if (useRandom) begin
        for (int k = 0; k < samplesPerClock; k++) begin
            rawValue = $random(seed);
            vec[k] = {rawValue[adcWidth-1:0], {(laneWidth - adcWidth){1'b0}}};
        end
    end else begin
        vec = countedSamples(beatCount);
    end
    samples     = vec;
    sampleValid = valid;
    // Taken at the coming rising edge
    entry.entryCycle = cycleCount + 1;
    entry.valid      = valid;
    entry.samples    = vec;
    driveLog.push_back(entry);
    beatCount++;
endtask

task automatic quietBeats(input int count);
    repeat (count) driveBeat(1'b1, 1'b0);
endtask

task automatic armChannel(input triggerBus enableMask);
    triggerEnable = enableMask;
    arm = 1'b1;
    driveBeat(1'b1, 1'b0);
    arm = 1'b0;
    compareBit("armed", armed, 1'b1);
    compareBit("captureDone", captureDone, 1'b0);
endtask

////////////////////////////////////////
// Readout and capture checking

task automatic readWord(input int addr, output sampleVector data);
    int latency;
    latency = 0;
    @(negedge sysClk);
    rdAddr = addrWidth'(addr);
    rdReq  = 1'b1;
    // Seen at the first edge, acknowledged at the third
    while (rdAck !== 1'b1 && latency < 8) begin
        @(negedge sysClk);
        latency++;
    end
    if (rdAck !== 1'b1) begin
        reportFailure("rdAck never answered rdReq");
    end else if (latency != 3) begin
        reportFailure($sformatf("rdAck came %0d cycles after rdReq, expected 3", latency));
    end
    data  = rdData;
    rdReq = 1'b0;
    @(negedge sysClk);
    compareBit("rdAck", rdAck, 1'b1);
    @(negedge sysClk);
    compareBit("rdAck", rdAck, 1'b0);
endtask

// Valid beats from the trigger on, as the buffer should hold them
task automatic expectedRecord(input int triggerCycle, output int lastCycle);
    int stored;
    stored    = 0;
    lastCycle = -1;
    foreach (driveLog[i]) begin
        if (driveLog[i].entryCycle >= triggerCycle && driveLog[i].valid
                && stored < recordDepth) begin
            expectedWords[stored] = driveLog[i].samples;
            lastCycle = driveLog[i].entryCycle;
            stored++;
        end
    end
endtask

task automatic runCapture(input int triggerCycle, input bit withGaps);
    int          waited;
    int          lastCycle;
    logic        beatValid;
    sampleVector word;
    waited = 0;
    while (captureDone !== 1'b1 && waited < 6 * recordDepth) begin
        // Every third beat dropped in gap mode
        beatValid = !(withGaps && (beatCount % 3 == 1));
        driveBeat(beatValid, 1'b0);
        waited++;
    end
    if (captureDone !== 1'b1) begin
        reportFailure("captureDone never rose after the trigger");
        return;
    end
    expectedRecord(triggerCycle, lastCycle);
    // Last store four edges after its beat entered
    if (cycleCount != lastCycle + 4) begin
        reportFailure($sformatf("captureDone seen in cycle %0d, expected cycle %0d",
                                cycleCount, lastCycle + 4));
    end
    compareBit("armed", armed, 1'b0);
    for (int i = 0; i < recordDepth; i++) begin
        readWord(i, word);
        compareBeat("rdData", word, expectedWords[i]);
    end
endtask

////////////////////////////////////////
// Directed tests

task automatic resetTest();
    sampleVector word;
    compareBit("armed", armed, 1'b0);
    compareBit("captureDone", captureDone, 1'b0);
    compareBit("rdAck", rdAck, 1'b0);
    // Nothing stored yet, handshake timing only
    readWord(0, word);
endtask

task automatic eventCaptureTest();
    int triggerCycle;
    quietBeats(6);
    armChannel(triggerBus'(1 << 3));
    quietBeats(3);
    driveBeat(1'b1, 1'b0);
    triggerCycle = driveLog[$].entryCycle;
    eventTriggers[2] = 1'b1;
    runCapture(triggerCycle, 1'b0);
    eventTriggers = '0;
endtask

task automatic softTriggerTest();
    int triggerCycle;
    quietBeats(6);
    armChannel(triggerBus'(1));
    quietBeats(3);
    driveBeat(1'b1, 1'b0);
    softTrigger = 1'b1;
    driveBeat(1'b1, 1'b0);
    // Beat after the pulse carries the strobe
    triggerCycle = driveLog[$].entryCycle;
    softTrigger = 1'b0;
    runCapture(triggerCycle, 1'b0);
endtask

task automatic enableMaskTest();
    int triggerCycle;
    quietBeats(6);
    armChannel(triggerBus'(1 << 5));
    quietBeats(2);
    // Event bit 1 is bus bit 2, masked off
    eventTriggers[1] = 1'b1;
    // Long enough for a wrongly started record to finish
    quietBeats(24);
    compareBit("armed", armed, 1'b1);
    compareBit("captureDone", captureDone, 1'b0);
    driveBeat(1'b1, 1'b0);
    triggerCycle = driveLog[$].entryCycle;
    eventTriggers[4] = 1'b1;
    runCapture(triggerCycle, 1'b0);
    eventTriggers = '0;
endtask

task automatic rangeTest();
    logic signed [adcWidth-1:0] expMin;
    logic signed [adcWidth-1:0] expMax;
    logic signed [adcWidth-1:0] code;
    sampleVector                lastVec;
    rangeStatus                 expected;
    repeat (4) driveBeat(1'b0, 1'b0);
    rangeClear = 1'b1;
    driveBeat(1'b0, 1'b0);
    rangeClear = 1'b0;
    driveBeat(1'b0, 1'b0);
    // Cleared state is the inverted extremes
    expMin = {1'b0, {(adcWidth - 1){1'b1}}};
    expMax = {1'b1, {(adcWidth - 1){1'b0}}};
    expected.minSample = expMin;
    expected.maxSample = expMax;
    compareRange("range", range, expected);
    repeat (24) begin
        driveBeat(1'b1, 1'b1);
        lastVec = driveLog[$].samples;
        for (int k = 0; k < samplesPerClock; k++) begin
            code = lastVec[k][laneWidth-1 -: adcWidth];
            if (code < expMin) begin
                expMin = code;
            end
            if (code > expMax) begin
                expMax = code;
            end
        end
    end
    // Entry edge and three stages to the monitor output
    repeat (4) driveBeat(1'b0, 1'b0);
    expected.minSample = expMin;
    expected.maxSample = expMax;
    compareRange("range", range, expected);
endtask

task automatic validGapTest();
    int triggerCycle;
    quietBeats(6);
    armChannel(triggerBus'(1 << 3));
    quietBeats(2);
    driveBeat(1'b1, 1'b0);
    triggerCycle = driveLog[$].entryCycle;
    eventTriggers[2] = 1'b1;
    runCapture(triggerCycle, 1'b1);
    eventTriggers = '0;
endtask

`endif

// File: tbHsdDigitizer.sv
`timescale 1ns/1ps

module tbHsdDigitizer import hsdPkg::*; ();

    localparam int recordDepth = 16;
    localparam int addrWidth = $clog2(recordDepth);

    // Four captures with 16 reads each come to about 600 cycles
    localparam int cycleLimit = 4000;

    typedef struct packed {
        int          entryCycle;
        logic        valid;
        sampleVector samples;
    } drivenBeat;

    logic                         sysClk;
    logic                         rst;
    sampleVector                  samples;
    logic                         sampleValid;
    logic [eventTriggerCount-1:0] eventTriggers;
    logic                         softTrigger;
    logic                         rangeClear;
    triggerBus                    triggerEnable;
    logic                         arm;
    logic                         rdReq;
    logic [addrWidth-1:0]         rdAddr;
    rangeStatus                   range;
    logic                         armed;
    logic                         captureDone;
    logic                         rdAck;
    sampleVector                  rdData;

    int          errorCount = 0;
    int          checkCount = 0;
    int          cycleCount = 0;
    int          beatCount = 0;
    integer      seed = 32'heb7cf160;

    // Every beat driven, with the edge that took it
    drivenBeat   driveLog [$];
    sampleVector expectedWords [recordDepth];

    hsdDigitizer #(
        .captureDepth (recordDepth)
    ) hsdDigitizer_inst (
        .sysClk        (sysClk),
        .rst           (rst),
        .samples       (samples),
        .sampleValid   (sampleValid),
        .eventTriggers (eventTriggers),
        .softTrigger   (softTrigger),
        .rangeClear    (rangeClear),
        .triggerEnable (triggerEnable),
        .arm           (arm),
        .rdReq         (rdReq),
        .rdAddr        (rdAddr),
        .range         (range),
        .armed         (armed),
        .captureDone   (captureDone),
        .rdAck         (rdAck),
        .rdData        (rdData)
    );

    `include "tbHsdTasks.svh"

    ////////////////////////////////////////
    // Clock, cycle count and watchdog

    initial begin
        sysClk = 1'b0;
        forever #5 sysClk = ~sysClk;
    end

    always @(posedge sysClk) begin
        cycleCount <= cycleCount + 1;
    end

    initial begin
        wait (cycleCount >= cycleLimit);
        $display("Timeout: run stopped after %0d cycles", cycleCount);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        $display("TB FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // Test sequence

    initial begin
        rst           = 1'b1;
        samples       = '0;
        sampleValid   = 1'b0;
        eventTriggers = '0;
        softTrigger   = 1'b0;
        rangeClear    = 1'b0;
        triggerEnable = '0;
        arm           = 1'b0;
        rdReq         = 1'b0;
        rdAddr        = '0;
        repeat (3) @(posedge sysClk);
        @(negedge sysClk);
        rst = 1'b0;

        resetTest();
        eventCaptureTest();
        softTriggerTest();
        enableMaskTest();
        rangeTest();
        validGapTest();

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: triggerConditioner.sv
`timescale 1ns/1ps

module triggerConditioner import hsdPkg::*; (
    input  logic                         sysClk,
    input  logic                         rst,
    input  sampleVector                  samples,
    input  logic                         sampleValid,
    input  logic                         softTrigger,
    input  logic [eventTriggerCount-1:0] eventTriggers,
    output sampleBeat                    stageOneBeat
);

    logic [3:0]  softStretch;
    logic        softLevel;
    triggerBus   triggerMeta;
    triggerBus   triggerLevel;
    triggerBus   triggerLevelDelay;
    triggerBus   risingEdges;
    sampleVector samplesD1;
    sampleVector samplesD2;
    logic        validD1;
    logic        validD2;

    ////////////////////////////////////////
    // Software trigger stretch

    // Top bit holds the level for 8 cycles
    assign softLevel = softStretch[3];

    always_ff @(posedge sysClk) begin
        if (rst) begin
            softStretch <= '0;
        end else if (softTrigger) begin
            // Reload while high keeps the level, no new edge
            softStretch <= '1;
        end else if (softLevel) begin
            softStretch <= softStretch - 1'b1;
        end
    end

    ////////////////////////////////////////
    // Synchronizer and edge detect

    always_ff @(posedge sysClk) begin
        if (rst) begin
            triggerMeta       <= '0;
            triggerLevel      <= '0;
            triggerLevelDelay <= '0;
        end else begin
            triggerMeta       <= {eventTriggers, softLevel};
            triggerLevel      <= triggerMeta;
            triggerLevelDelay <= triggerLevel;
        end
    end

    assign risingEdges = triggerLevel & ~triggerLevelDelay;

    ////////////////////////////////////////
    // Sample alignment

    // Two stages here, the third is the output beat
    always_ff @(posedge sysClk) begin
        samplesD1 <= samples;
        samplesD2 <= samplesD1;
    end

    always_ff @(posedge sysClk) begin
        if (rst) begin
            validD1 <= 1'b0;
            validD2 <= 1'b0;
        end else begin
            validD1 <= sampleValid;
            validD2 <= validD1;
        end
    end

    // Strobe lands with the sample taken when the edge first arrived
    always_ff @(posedge sysClk) begin
        if (rst) begin
            stageOneBeat.valid          <= 1'b0;
            stageOneBeat.triggerStrobes <= '0;
        end else begin
            stageOneBeat.valid          <= validD2;
            stageOneBeat.triggerStrobes <= risingEdges;
        end
        stageOneBeat.samples <= samplesD2;
    end

    // Each strobe covers one beat only
    strobeSingleBeat: assert property (
        @(posedge sysClk) disable iff (rst)
        (stageOneBeat.triggerStrobes & $past(stageOneBeat.triggerStrobes)) == '0
    ) else $error("Trigger strobe high on consecutive beats");

endmodule
